/* hw/alarmBank.sv */
// the 24 alarms and countdown timers, each compared against one clock
// an alarm fires when its clock ticks from the stored value. the data bit
// goes high for finishLen cycles from the next cycle on
module alarmBank (
  input  logic                                                  clk_2x,
  input  logic                                                  reset,
  alarmCmdIf.bank                                               cmdA,
  alarmCmdIf.bank                                               cmdB,
  input  logic [atsParamPkg::numClocks-1:0][atsParamPkg::countW-1:0] counts,
  input  logic [atsParamPkg::numClocks-1:0]                     ticks,
  output logic [atsParamPkg::numAlarms-1:0]                     data
);
  import atsParamPkg::*;

  logic [numAlarms-1:0]               en;
  logic [numAlarms-1:0]               rpt;     // rearm after firing
  logic [numAlarms-1:0][clkIdxW-1:0]  clkSel;
  logic [numAlarms-1:0][countW-1:0]   value;
  logic [numAlarms-1:0][pulseW-1:0]   pulse;   // cycles of data left
  logic [numAlarms-1:0]               fire;

  // count before the increment must match
  always_comb begin
    for (int a = 0; a < numAlarms; a++) begin
      fire[a] = en[a] && ticks[clkSel[a]] && (counts[clkSel[a]] == value[a]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control state and finished pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      en     <= '0;
      rpt    <= '0;
      clkSel <= '0;
      pulse  <= '0;
    end else begin
      for (int a = 0; a < numAlarms; a++) begin
        if (fire[a]) begin
          pulse[a] <= pulseW'(finishLen);  // restart even mid pulse
          if (!rpt[a]) en[a] <= 1'b0;      // one-shot disarms
        end else if (pulse[a] != '0) begin
          pulse[a] <= pulse[a] - 1'b1;
        end
      end
      // a setup arms the alarm, an enable command only flips en
      if (cmdA.valid) begin
        if (cmdA.setup) begin
          rpt[cmdA.idx]    <= cmdA.repeatMode;
          clkSel[cmdA.idx] <= cmdA.clkIdx;
          en[cmdA.idx]     <= 1'b1;
        end else begin
          en[cmdA.idx] <= cmdA.enable;
        end
      end
      if (cmdB.valid) begin
        if (cmdB.setup) begin
          rpt[cmdB.idx]    <= cmdB.repeatMode;
          clkSel[cmdB.idx] <= cmdB.clkIdx;
          en[cmdB.idx]     <= 1'b1;
        end else begin
          en[cmdB.idx] <= cmdB.enable;
        end
      end
    end
  end

  // alarm values, a timer adds the current count of its clock
  always_ff @(posedge clk_2x) begin
    if (cmdA.valid && cmdA.setup) begin
      value[cmdA.idx] <= cmdA.isTimer ? cmdA.value + counts[cmdA.clkIdx] : cmdA.value;
    end
    if (cmdB.valid && cmdB.setup) begin
      value[cmdB.idx] <= cmdB.isTimer ? cmdB.value + counts[cmdB.clkIdx] : cmdB.value;
    end
  end

  always_comb begin
    for (int a = 0; a < numAlarms; a++) data[a] = (pulse[a] != '0);
  end

endmodule

/* hw/atsIfs.sv */
// command buses from the arbiter to the clock and alarm banks
// one instance per client, single-cycle strobe, no back-pressure
// the arbiter never sends both instances to the same index in a cycle

interface clockCmdIf;
  import atsParamPkg::*;

  logic               valid;   // execute this cycle
  logic               load;    // 1 = set clock, 0 = enable only
  logic [clkIdxW-1:0] idx;
  logic [rateW-1:0]   rate;
  logic [countW-1:0]  count;
  logic               enable;

  modport arb (output valid, load, idx, rate, count, enable);
  modport bank (input valid, load, idx, rate, count, enable);

endinterface

interface alarmCmdIf;
  import atsParamPkg::*;

  logic                 valid;       // execute this cycle
  logic                 setup;       // 1 = set alarm / timer, 0 = enable only
  logic [alarmIdxW-1:0] idx;
  logic [clkIdxW-1:0]   clkIdx;      // clock the alarm watches
  logic [countW-1:0]    value;       // absolute value or timer duration
  logic                 isTimer;     // value is relative to current count
  logic                 repeatMode;  // stays armed after firing
  logic                 enable;

  modport arb (
    output valid, setup, idx, clkIdx, value, isTimer, repeatMode, enable
  );
  modport bank (
    input valid, setup, idx, clkIdx, value, isTimer, repeatMode, enable
  );

endinterface

/* hw/atsInstrPkg.sv */
// 32-bit client instruction, upper half arrives first on ctrlA / ctrlB
// the same word decodes as a clock, an alarm or a mode instruction
// opcode always sits in the top three bits
package atsInstrPkg;
  import atsParamPkg::*;

  localparam int instrW = 32;
  localparam int opW    = 3;

  // opcodes
  localparam logic [opW-1:0] opNop      = 3'd0;
  localparam logic [opW-1:0] opSetClock = 3'd1;  // load count, rate, enable
  localparam logic [opW-1:0] opEnClock  = 3'd2;  // enable bit only
  localparam logic [opW-1:0] opMode     = 3'd3;  // issuing client's permissions
  localparam logic [opW-1:0] opSetAlarm = 3'd5;  // en bit means repeat
  localparam logic [opW-1:0] opSetTimer = 3'd6;  // value is a duration
  localparam logic [opW-1:0] opEnAlarm  = 3'd7;  // enable bit only

  typedef union packed {
    struct packed {
      logic [opW-1:0]     opcode;  // 31:29
      logic [clkIdxW-1:0] idx;     // 28:25
      logic               en;      // 24
      logic [rateW-1:0]   rate;    // 23:22
      logic [5:0]         rsvd;    // 21:16
      logic [countW-1:0]  count;   // 15:0
    } clk;
    struct packed {
      logic [opW-1:0]       opcode;  // 31:29
      logic [alarmIdxW-1:0] idx;     // 28:24
      logic                 en;      // 23, repeat for set alarm
      logic [2:0]           rsvd;    // 22:20
      logic [clkIdxW-1:0]   clkIdx;  // 19:16
      logic [countW-1:0]    value;   // 15:0, alarm value or timer duration
    } alm;
    struct packed {
      logic [opW-1:0] opcode;     // 31:29
      logic [2:0]     rsvdHi;     // 28:26
      logic           clkPerm;    // 25
      logic           alarmPerm;  // 24
      logic [23:0]    rsvdLo;
    } mode;
  } atsInstr;

endpackage

/* hw/atsParamPkg.sv */
// device sizes for the clock, alarm and timer block
// shared by every RTL block and the testbench, import with atsParamPkg::*
package atsParamPkg;

  localparam int numClocks = 16;            // software clocks
  localparam int clkIdxW   = 4;             // clock select width
  localparam int numAlarms = 24;            // alarms and timers
  localparam int alarmIdxW = 5;             // alarm select width
  localparam int countW    = 16;            // counter and alarm value
  localparam int rateW     = 2;             // rate field

  // rate codes, code 3 holds the count
  localparam logic [rateW-1:0] rate1x = 2'd0;  // every cycle
  localparam logic [rateW-1:0] rate2x = 2'd1;  // every 2nd cycle
  localparam logic [rateW-1:0] rate4x = 2'd2;  // every 4th cycle

  // finished pulse on data, in cycles
  localparam int finishLen = 2;
  localparam int pulseW    = $clog2(finishLen + 1);

  // per client status bit
  localparam logic ackVal  = 1'b1;
  localparam logic nackVal = 1'b0;

endpackage

/* hw/atsTop.sv */
// top of the clock / alarm / timer block, single clk_2x domain
// client A and B send instructions in two halves on ctrlA / ctrlB,
// stat[0] answers A and stat[1] answers B, data has one bit per alarm
module atsTop (
  input  logic        clk_2x,
  input  logic        reset,
  input  logic        req,
  input  logic [15:0] ctrlA,
  input  logic [15:0] ctrlB,
  output logic [1:0]  stat,
  output logic [23:0] data
);

  logic             validA, validB;
  logic [31:0]      instrA, instrB;  // assembled words
  logic [15:0][15:0] counts;         // clock counts to the alarms
  logic [15:0]      ticks;

  clockCmdIf clkCmdA ();
  clockCmdIf clkCmdB ();
  alarmCmdIf alarmCmdA ();
  alarmCmdIf alarmCmdB ();

  // instruction intake, one per client
  instrCapture capA (
    .clk_2x, .reset, .req, .ctrl(ctrlA), .instrValid(validA), .instr(instrA)
  );
  instrCapture capB (
    .clk_2x, .reset, .req, .ctrl(ctrlB), .instrValid(validB), .instr(instrB)
  );

  cmdArbiter arbiter (
    .clk_2x, .reset,
    .validA, .instrA, .validB, .instrB,
    .stat,
    .clkCmdA, .clkCmdB, .alarmCmdA, .alarmCmdB
  );

  clockBank clocks (
    .clk_2x, .reset, .cmdA(clkCmdA), .cmdB(clkCmdB), .counts, .ticks
  );

  alarmBank alarms (
    .clk_2x, .reset, .cmdA(alarmCmdA), .cmdB(alarmCmdB), .counts, .ticks, .data
  );

endmodule

/* hw/clockBank.sv */
// the 16 software clocks: one free-running prescaler, per clock an
// enable, a rate and a counter. ticks marks the edges where a clock counts
module clockBank (
  input  logic                                                  clk_2x,
  input  logic                                                  reset,
  clockCmdIf.bank                                               cmdA,
  clockCmdIf.bank                                               cmdB,
  output logic [atsParamPkg::numClocks-1:0][atsParamPkg::countW-1:0] counts,
  output logic [atsParamPkg::numClocks-1:0]                     ticks
);
  import atsParamPkg::*;

  logic [1:0]                       prescaler;  // phase for 2x and 4x
  logic [numClocks-1:0]             en;
  logic [numClocks-1:0][rateW-1:0]  rate;

  // does a clock at rate r count in this prescaler phase
  function automatic logic rateHit(input logic [rateW-1:0] r, input logic [1:0] phase);
    case (r)
      rate1x:  rateHit = 1'b1;
      rate2x:  rateHit = (phase[0] == 1'b0);
      rate4x:  rateHit = (phase == 2'd0);
      default: rateHit = 1'b0;  // stopped
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < numClocks; i++) ticks[i] = en[i] && rateHit(rate[i], prescaler);
  end

  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      prescaler <= '0;
      en        <= '0;
      rate      <= '0;
      counts    <= '0;
    end else begin
      prescaler <= prescaler + 1'b1;
      for (int i = 0; i < numClocks; i++) begin
        if (ticks[i]) counts[i] <= counts[i] + 1'b1;
      end
      // commands win over the tick, A and B never share an index
      if (cmdA.valid) begin
        if (cmdA.load) begin
          counts[cmdA.idx] <= cmdA.count;
          rate[cmdA.idx]   <= cmdA.rate;
        end
        en[cmdA.idx] <= cmdA.enable;
      end
      if (cmdB.valid) begin
        if (cmdB.load) begin
          counts[cmdB.idx] <= cmdB.count;
          rate[cmdB.idx]   <= cmdB.rate;
        end
        en[cmdB.idx] <= cmdB.enable;
      end
    end
  end

endmodule

/* hw/cmdArbiter.sv */
// decodes the words of both clients and sends them to the banks
// same clock or same alarm from both clients in one cycle: both Nack,
// nothing applied. holds each client's permissions and the stat bits
module cmdArbiter (
  input  logic                 clk_2x,
  input  logic                 reset,
  input  logic                 validA,
  input  atsInstrPkg::atsInstr instrA,
  input  logic                 validB,
  input  atsInstrPkg::atsInstr instrB,
  output logic [1:0]           stat,
  clockCmdIf.arb               clkCmdA,
  clockCmdIf.arb               clkCmdB,
  alarmCmdIf.arb               alarmCmdA,
  alarmCmdIf.arb               alarmCmdB
);
  import atsParamPkg::*;
  import atsInstrPkg::*;

  // index 0 is client A, 1 is client B
  atsInstr    instr [2];
  logic [1:0] valid;
  logic [1:0] isClk, isAlm, isMode;  // opcode class per client
  logic [1:0] goClk, goAlm;          // permitted and free of conflict
  logic [1:0] ackNext;
  logic [1:0] permClk, permAlm;      // mode bits
  logic       conflict;

  assign instr[0] = instrA;
  assign instr[1] = instrB;
  assign valid    = {validB, validA};

  //////////////////////////////////////////////////////////////////////
  // decode and conflict check
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      isClk[c]  = valid[c] && (instr[c].clk.opcode inside {opSetClock, opEnClock});
      isAlm[c]  = valid[c] &&
                  (instr[c].alm.opcode inside {opSetAlarm, opSetTimer, opEnAlarm});
      isMode[c] = valid[c] && (instr[c].mode.opcode == opMode);
    end
    // clock index and alarm index sit in different bits
    conflict = (isClk[0] && isClk[1] && (instr[0].clk.idx == instr[1].clk.idx)) ||
               (isAlm[0] && isAlm[1] && (instr[0].alm.idx == instr[1].alm.idx));
    for (int c = 0; c < 2; c++) begin
      goClk[c]   = isClk[c] && permClk[c] && !conflict;
      goAlm[c]   = isAlm[c] && permAlm[c] && !conflict;
      ackNext[c] = goClk[c] || goAlm[c] || isMode[c];  // nop, unknown -> Nack
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mode bits and status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      permClk <= 2'b11;  // everything allowed out of reset
      permAlm <= 2'b11;
      stat    <= {nackVal, nackVal};
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (isMode[c]) begin
          permClk[c] <= instr[c].mode.clkPerm;  // own flags only
          permAlm[c] <= instr[c].mode.alarmPerm;
        end
        stat[c] <= ackNext[c] ? ackVal : nackVal;  // one cycle, then Nack
      end
    end
  end

  // clock commands
  assign clkCmdA.valid  = goClk[0];
  assign clkCmdA.load   = (instrA.clk.opcode == opSetClock);
  assign clkCmdA.idx    = instrA.clk.idx;
  assign clkCmdA.rate   = instrA.clk.rate;
  assign clkCmdA.count  = instrA.clk.count;
  assign clkCmdA.enable = instrA.clk.en;

  assign clkCmdB.valid  = goClk[1];
  assign clkCmdB.load   = (instrB.clk.opcode == opSetClock);
  assign clkCmdB.idx    = instrB.clk.idx;
  assign clkCmdB.rate   = instrB.clk.rate;
  assign clkCmdB.count  = instrB.clk.count;
  assign clkCmdB.enable = instrB.clk.en;

  // alarm commands, a timer never repeats
  assign alarmCmdA.valid      = goAlm[0];
  assign alarmCmdA.setup      = (instrA.alm.opcode != opEnAlarm);
  assign alarmCmdA.idx        = instrA.alm.idx;
  assign alarmCmdA.clkIdx     = instrA.alm.clkIdx;
  assign alarmCmdA.value      = instrA.alm.value;
  assign alarmCmdA.isTimer    = (instrA.alm.opcode == opSetTimer);
  assign alarmCmdA.repeatMode = instrA.alm.en && (instrA.alm.opcode == opSetAlarm);
  assign alarmCmdA.enable     = instrA.alm.en;

  assign alarmCmdB.valid      = goAlm[1];
  assign alarmCmdB.setup      = (instrB.alm.opcode != opEnAlarm);
  assign alarmCmdB.idx        = instrB.alm.idx;
  assign alarmCmdB.clkIdx     = instrB.alm.clkIdx;
  assign alarmCmdB.value      = instrB.alm.value;
  assign alarmCmdB.isTimer    = (instrB.alm.opcode == opSetTimer);
  assign alarmCmdB.repeatMode = instrB.alm.en && (instrB.alm.opcode == opSetAlarm);
  assign alarmCmdB.enable     = instrB.alm.en;

endmodule

/* hw/instrCapture.sv */
// collects one client's instruction from two 16-bit halves
// req with a nonzero opcode marks the upper half, the next cycle carries
// the lower half and the whole word is presented with a one-cycle strobe
module instrCapture (
  input  logic                 clk_2x,
  input  logic                 reset,
  input  logic                 req,
  input  logic [15:0]          ctrl,
  output logic                 instrValid,
  output atsInstrPkg::atsInstr instr
);
  import atsInstrPkg::*;

  logic [15:0] upperHalf;  // held for one cycle
  logic        pending;    // upper half in, lower half on ctrl now
  logic        start;

  // idle, req high and a real opcode in the top bits
  assign start = !pending && req && (ctrl[15 -: opW] != opNop);

  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else begin
      pending <= start;  // drops again at the lower-half edge
    end
  end

  always_ff @(posedge clk_2x) begin
    if (start) upperHalf <= ctrl;
  end

  assign instrValid = pending;
  assign instr      = {upperHalf, ctrl};  // lower half straight from the pins

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, exit status 0 on pass
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module atsTb \
  -f vlog.f -o atsSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/atsSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  echo "testbench reported failure"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

/* tests/atsTb.sv */
// testbench for atsTop with random instructions from both clients
// checked every cycle against a cycle model of capture, arbitration, clocks and alarms
// run through run.sh and closes with the test and error counts
module atsTb;
  timeunit 1ns;
  timeprecision 1ns;
  import atsParamPkg::*;
  import atsInstrPkg::*;

  logic                 clk_2x, reset, req;
  logic [15:0]          ctrlA, ctrlB;
  logic [1:0]           stat;
  logic [numAlarms-1:0] data;
  int errors, tests, failed;

  // cycle model state
  logic [1:0]  mPend, mPermC, mPermA, mStat, mPre;
  logic [15:0] mUpper [2];
  logic [numClocks-1:0] cEn;
  logic [rateW-1:0]     cRate [numClocks];
  logic [countW-1:0]    cCnt [numClocks];
  logic [numAlarms-1:0] aEn, aRpt;
  logic [clkIdxW-1:0]   aSel [numAlarms];
  logic [countW-1:0]    aVal [numAlarms];
  int                   aPulse [numAlarms];

  atsTop u_dut (.clk_2x, .reset, .req, .ctrlA, .ctrlB, .stat, .data);

  initial begin
    clk_2x = 1'b0;
    forever #5 clk_2x = ~clk_2x;  // 10 ns period
  end

  initial begin
    #1ms;  // whole run guard
    $display("timeout: simulation did not reach the end of the tests");
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // cycle model, one step per rising edge
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_2x or posedge reset) begin : model
    atsInstr w [2];
    logic [15:0] ctl [2];
    logic [1:0] isC, isA, isM, goC, goA;
    logic cf;
    logic [numClocks-1:0] tk;
    logic [numAlarms-1:0] fire;
    if (reset) begin
      mPend  = '0;
      mPermC = 2'b11;
      mPermA = 2'b11;
      mStat  = '0;
      mPre   = '0;
      cEn    = '0;
      aEn    = '0;
      aRpt   = '0;
      for (int i = 0; i < numClocks; i++) begin
        cRate[i] = '0;
        cCnt[i] = '0;
      end
      for (int a = 0; a < numAlarms; a++) begin
        aSel[a] = '0;
        aVal[a] = '0;
        aPulse[a] = 0;
      end
    end else begin
      ctl[0] = ctrlA;
      ctl[1] = ctrlB;
      for (int c = 0; c < 2; c++) begin
        w[c]   = {mUpper[c], ctl[c]};  // only used while pending
        isC[c] = mPend[c] && (w[c].clk.opcode inside {opSetClock, opEnClock});
        isA[c] = mPend[c] && (w[c].alm.opcode inside {opSetAlarm, opSetTimer, opEnAlarm});
        isM[c] = mPend[c] && (w[c].mode.opcode == opMode);
      end
      cf = (isC[0] && isC[1] && w[0].clk.idx == w[1].clk.idx) ||
           (isA[0] && isA[1] && w[0].alm.idx == w[1].alm.idx);
      goC = isC & mPermC & {2{!cf}};
      goA = isA & mPermA & {2{!cf}};
      // tick when the low r prescaler bits are zero
      for (int i = 0; i < numClocks; i++)
        tk[i] = cEn[i] && (cRate[i] == rate1x || (cRate[i] == rate2x && !mPre[0]) ||
                           (cRate[i] == rate4x && mPre == 2'd0));
      for (int a = 0; a < numAlarms; a++) begin
        fire[a] = aEn[a] && tk[aSel[a]] && (cCnt[aSel[a]] == aVal[a]);
        if (fire[a]) begin
          aPulse[a] = finishLen;
          if (!aRpt[a]) aEn[a] = 1'b0;
        end else if (aPulse[a] > 0) aPulse[a]--;
      end
      for (int c = 0; c < 2; c++) begin  // alarm commands see counts before the edge
        if (goA[c] && w[c].alm.opcode == opEnAlarm) aEn[w[c].alm.idx] = w[c].alm.en;
        else if (goA[c]) begin
          aEn[w[c].alm.idx]  = 1'b1;
          aRpt[w[c].alm.idx] = w[c].alm.en && (w[c].alm.opcode == opSetAlarm);
          aSel[w[c].alm.idx] = w[c].alm.clkIdx;
          aVal[w[c].alm.idx] = (w[c].alm.opcode == opSetTimer) ?
                               w[c].alm.value + cCnt[w[c].alm.clkIdx] : w[c].alm.value;
        end
      end
      for (int i = 0; i < numClocks; i++) if (tk[i]) cCnt[i]++;
      for (int c = 0; c < 2; c++) begin
        if (goC[c]) begin  // command beats the tick
          cEn[w[c].clk.idx] = w[c].clk.en;
          if (w[c].clk.opcode == opSetClock) begin
            cCnt[w[c].clk.idx]  = w[c].clk.count;
            cRate[w[c].clk.idx] = w[c].clk.rate;
          end
        end
        mStat[c] = goC[c] || goA[c] || isM[c];
        if (isM[c]) begin
          mPermC[c] = w[c].mode.clkPerm;
          mPermA[c] = w[c].mode.alarmPerm;
        end
        if (!mPend[c] && req && ctl[c][15 -: opW] != opNop) begin
          mPend[c] = 1'b1;
          mUpper[c] = ctl[c];
        end else mPend[c] = 1'b0;
      end
      mPre++;
    end
  end

  task automatic checkStat(input logic [1:0] got, input logic [1:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t: stat %b, expected %b (%0s)", $time, got, exp, msg);
    end
  endtask

  task automatic checkData(input logic [numAlarms-1:0] got, input logic [numAlarms-1:0] exp,
                           input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t: data %h, expected %h (%0s)", $time, got, exp, msg);
    end
  endtask

  always @(negedge clk_2x) begin : compare  // outputs settled since the rising edge
    logic [numAlarms-1:0] expData;
    if (!reset) begin
      for (int a = 0; a < numAlarms; a++) expData[a] = (aPulse[a] != 0);
      checkStat(stat, mStat, "cycle model");
      checkData(data, expData, "cycle model");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic atsInstr clkWord(logic [2:0] op, int idx, logic en, logic [1:0] rate,
                                      logic [15:0] cnt);
    atsInstr w;
    w = '0;
    w.clk.opcode = op;
    w.clk.idx    = clkIdxW'(idx);
    w.clk.en     = en;
    w.clk.rate   = rate;
    w.clk.count  = cnt;
    return w;
  endfunction

  function automatic atsInstr almWord(logic [2:0] op, int idx, logic en, int clk,
                                      logic [15:0] val);
    atsInstr w;
    w = '0;
    w.alm.opcode = op;
    w.alm.idx    = alarmIdxW'(idx);
    w.alm.en     = en;
    w.alm.clkIdx = clkIdxW'(clk);
    w.alm.value  = val;
    return w;
  endfunction

  function automatic atsInstr modeWord(logic clkPerm, logic alarmPerm);
    atsInstr w;
    w = '0;
    w.mode.opcode    = opMode;
    w.mode.clkPerm   = clkPerm;
    w.mode.alarmPerm = alarmPerm;
    return w;
  endfunction

  // alarm values land within a few hundred cycles of the watched count
  function automatic atsInstr randWord();
    atsInstr w;
    w = atsInstr'($urandom);
    if (w.alm.opcode inside {opSetAlarm, opSetTimer, opEnAlarm}) begin
      w.alm.idx   = alarmIdxW'($urandom_range(0, numAlarms - 1));
      w.alm.value = 16'($urandom_range(3, 150));
      if (w.alm.opcode == opSetAlarm) w.alm.value += cCnt[w.alm.clkIdx];
    end
    return w;
  endfunction

  // both halves and then stat in its result cycle
  task automatic sendPair(input atsInstr wa, input logic va, input atsInstr wb,
                          input logic vb, input logic chk, input logic [1:0] expStat);
    @(negedge clk_2x);
    req   = 1'b1;
    ctrlA = va ? wa[31:16] : 16'h0;
    ctrlB = vb ? wb[31:16] : 16'h0;
    @(negedge clk_2x);
    req   = 1'($urandom_range(0, 1));  // lower half ignores req
    ctrlA = va ? wa[15:0] : 16'h0;
    ctrlB = vb ? wb[15:0] : 16'h0;
    @(negedge clk_2x);
    req = 1'b0;
    if (chk) checkStat(stat, expStat, "stat after instruction");
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_2x);
      req   = 1'b0;
      ctrlA = 16'($urandom);  // noise with req low
      ctrlB = 16'($urandom);
    end
  endtask

  task automatic waitFire(input int idx, input int limit, input string what);
    int n;
    n = 0;
    while (data[idx] !== 1'b1 && n < limit) begin
      @(negedge clk_2x);
      n++;
    end
    if (data[idx] !== 1'b1) begin
      errors++;
      $display("timeout: alarm %0d never fired within %0d cycles (%0s)", idx, limit, what);
    end
  endtask

  task automatic endTest(input string name, input int errBefore);
    tests++;
    if (errors == errBefore) $display("test %0s: passed", name);
    else begin
      failed++;
      $display("test %0s: failed with %0d errors", name, errors - errBefore);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int e0, k, a;
    logic [15:0] c0;
    errors = 0;
    tests  = 0;
    failed = 0;
    reset  = 1'b1;
    req    = 1'b0;
    ctrlA  = '0;
    ctrlB  = '0;
    void'($urandom(25929));
    repeat (16) @(posedge clk_2x);
    @(negedge clk_2x) reset = 1'b0;

    e0 = errors;  // alarm at each rate
    for (int r = 0; r < 3; r++) begin
      k = $urandom_range(0, numClocks - 1);
      a = $urandom_range(0, numAlarms - 1);
      c0 = 16'($urandom);
      sendPair(clkWord(opSetClock, k, 1'b1, 2'(r), c0), 1'b1, '0, 1'b0, 1'b1, 2'b01);
      sendPair('0, 1'b0, almWord(opSetAlarm, a, 1'b0, k, c0 + 16'($urandom_range(8, 40))),
               1'b1, 1'b1, 2'b10);
      waitFire(a, 400, "rate");
      idle(4);
    end
    endTest("rates", e0);

    e0 = errors;  // one-shot stays quiet while repeat rearms on reload
    k = $urandom_range(0, numClocks - 1);
    a = $urandom_range(0, numAlarms - 1);
    c0 = 16'($urandom);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1,
             almWord(opSetAlarm, a, 1'b0, k, c0 + 16'd20), 1'b1, 1'b1, 2'b11);
    waitFire(a, 100, "one-shot");
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    idle(40);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1,
             almWord(opSetAlarm, a, 1'b1, k, c0 + 16'd20), 1'b1, 1'b1, 2'b11);
    waitFire(a, 100, "repeat");
    idle(5);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    waitFire(a, 100, "repeat again");
    endTest("repeat", e0);

    e0 = errors;  // countdown from the count at execution
    k = $urandom_range(0, numClocks - 1);
    a = $urandom_range(0, numAlarms - 1);
    sendPair(clkWord(opSetClock, k, 1'b1, 2'($urandom_range(0, 2)), 16'($urandom)), 1'b1,
             '0, 1'b0, 1'b1, 2'b01);
    sendPair('0, 1'b0, almWord(opSetTimer, a, 1'b0, k, 16'($urandom_range(8, 60))), 1'b1,
             1'b1, 2'b10);
    waitFire(a, 300, "timer");
    endTest("timer", e0);

    e0 = errors;  // disable and re-enable a clock and then an armed alarm
    c0 = 16'($urandom);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1,
             almWord(opSetAlarm, a, 1'b0, k, c0 + 16'd40), 1'b1, 1'b1, 2'b11);
    sendPair(clkWord(opEnClock, k, 1'b0, 2'd0, 16'd0), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    idle(100);
    sendPair(clkWord(opEnClock, k, 1'b1, 2'd0, 16'd0), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    waitFire(a, 200, "clock enable");
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1,
             almWord(opSetAlarm, a, 1'b0, k, c0 + 16'd40), 1'b1, 1'b1, 2'b11);
    sendPair('0, 1'b0, almWord(opEnAlarm, a, 1'b0, 0, 16'd0), 1'b1, 1'b1, 2'b10);
    idle(80);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, c0), 1'b1,
             almWord(opEnAlarm, a, 1'b1, 0, 16'd0), 1'b1, 1'b1, 2'b11);
    waitFire(a, 200, "alarm enable");
    endTest("enable", e0);

    e0 = errors;  // same target from both clients
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, 16'd0), 1'b1,
             clkWord(opEnClock, k, 1'b0, 2'd0, 16'd0), 1'b1, 1'b1, 2'b00);
    sendPair(almWord(opSetTimer, a, 1'b0, k, 16'd5), 1'b1,
             almWord(opEnAlarm, a, 1'b1, k, 16'd0), 1'b1, 1'b1, 2'b00);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, 16'd0), 1'b1,
             clkWord(opSetClock, k ^ 1, 1'b1, rate2x, 16'd0), 1'b1, 1'b1, 2'b11);
    idle(20);
    endTest("conflict", e0);

    e0 = errors;  // permissions per client
    sendPair(modeWord(1'b0, 1'b1), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    sendPair(clkWord(opSetClock, k, 1'b1, rate1x, 16'd0), 1'b1,
             clkWord(opSetClock, k ^ 1, 1'b1, rate1x, 16'd0), 1'b1, 1'b1, 2'b10);
    sendPair(almWord(opSetTimer, a, 1'b0, k, 16'd9), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    sendPair(modeWord(1'b1, 1'b0), 1'b1, '0, 1'b0, 1'b1, 2'b01);
    sendPair(almWord(opSetTimer, a, 1'b0, k, 16'd9), 1'b1,
             almWord(opSetTimer, a ^ 1, 1'b0, k, 16'd9), 1'b1, 1'b1, 2'b10);
    sendPair(modeWord(1'b1, 1'b1), 1'b1, modeWord(1'b1, 1'b1), 1'b1, 1'b1, 2'b11);
    idle(30);
    endTest("mode", e0);

    e0 = errors;  // random mix checked every cycle by the model
    for (int n = 0; n < 200; n++) begin
      sendPair(randWord(), 1'($urandom_range(0, 1)), randWord(), 1'($urandom_range(0, 1)),
               1'b0, 2'b00);
      idle($urandom_range(0, 6));
    end
    idle(300);
    endTest("random", e0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tests/atsTop_asserts.sv */
// concurrent checks on the stat and data outputs of atsTop
// bound into atsTop by the bind at the end of this file
module atsTop_asserts (
  input logic                                 clk_2x,
  input logic                                 reset,
  input logic [1:0]                           stat,
  input logic [atsParamPkg::numAlarms-1:0]    data
);
  timeunit 1ns;
  timeprecision 1ns;
  import atsParamPkg::*;

  statKnown: assert property (@(posedge clk_2x) disable iff (reset) !$isunknown(stat))
    else $error("stat carries X after reset");

  // a result lasts one cycle, captures are at least two apart
  for (genvar c = 0; c < 2; c++) begin : statBit
    ackOnce: assert property (@(posedge clk_2x) disable iff (reset)
                              stat[c] == ackVal |=> stat[c] == nackVal)
      else $error("stat bit %0d held Ack for two cycles", c);
  end

  for (genvar a = 0; a < numAlarms; a++) begin : dataBit
    pulseHeld: assert property (@(posedge clk_2x) disable iff (reset)
                                $rose(data[a]) |=> data[a])
      else $error("finished pulse of alarm %0d lasted one cycle", a);
  end

endmodule

bind atsTop atsTop_asserts u_asserts (.clk_2x, .reset, .stat, .data);

/* vlog.f */
hw/atsParamPkg.sv
hw/atsInstrPkg.sv
hw/atsIfs.sv
hw/instrCapture.sv
hw/cmdArbiter.sv
hw/clockBank.sv
hw/alarmBank.sv
hw/atsTop.sv
tests/atsTop_asserts.sv
tests/atsTb.sv
